//--- src.f
+incdir+tb
src/isa_pkg.sv
src/core_pkg.sv
src/fetch.sv
src/reg_file.sv
src/decode.sv
src/execute.sv
src/data_mem.sv
src/result.sv
src/proc.sv
tb/proc_tb.sv

//--- tb/proc_ref.svh
`ifndef PROC_REF_SVH
`define PROC_REF_SVH

// Architectural state of the reference model
logic [15:0] ref_regs [8];
logic [15:0] ref_mem [256];
logic [15:0] ref_pc;
logic        ref_halted;
logic        ref_err;
logic [31:0] lfsr_state;

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [15:0] rand_bits(input int n);
   logic [15:0] v;
   logic        fb;
   v = '0;
   for (int k = 0; k < n; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[14:0], fb};
   end
   return v;
endfunction

function automatic void reset_ref();
   for (int k = 0; k < 8; k++) begin
      ref_regs[k] = '0;
   end
   ref_pc     = '0;
   ref_halted = 1'b0;
   ref_err    = 1'b0;
endfunction

function automatic void set_write(inout retire_t r, input logic [2:0] rg,
                                  input logic [15:0] d);
   r.wr_en   = 1'b1;
   r.wr_reg  = rg;
   r.wr_data = d;
endfunction

// Executes one instruction on the model and returns what the core should report
function automatic retire_t ref_step(input logic [15:0] word);
   instr_u      i;
   retire_t     r;
   logic [15:0] a;
   logic [15:0] b;
   logic [15:0] s5;
   logic [15:0] s8;
   logic [15:0] s11;
   logic [15:0] addr;
   logic [15:0] nxt;
   i    = word;
   r    = '0;
   a    = ref_regs[i.r.rs];
   b    = ref_regs[i.r.rt];
   s5   = {{11{i.i1.imm[4]}}, i.i1.imm};
   s8   = {{8{i.i2.imm[7]}}, i.i2.imm};
   s11  = {{5{i.j.disp[10]}}, i.j.disp};
   addr = a + s5;
   nxt  = ref_pc + 16'd1;
   r.valid = 1'b1;
   r.pc    = ref_pc;
   case (i.r.opcode)
      op_halt: ref_halted = 1'b1;
      op_nop: ;
      op_alu: begin
         case (i.r.func)
            fn_add:  set_write(r, i.r.rd, a + b);
            fn_sub:  set_write(r, i.r.rd, b - a);
            fn_xor:  set_write(r, i.r.rd, a ^ b);
            default: set_write(r, i.r.rd, a & ~b);
         endcase
      end
      op_addi:  set_write(r, i.i1.rd, a + s5);
      op_subi:  set_write(r, i.i1.rd, s5 - a);
      op_xori:  set_write(r, i.i1.rd, a ^ s5);
      op_andni: set_write(r, i.i1.rd, a & ~s5);
      op_seq:   set_write(r, i.r.rd, {15'd0, a == b});
      op_slt:   set_write(r, i.r.rd, {15'd0, $signed(a) < $signed(b)});
      op_sle:   set_write(r, i.r.rd, {15'd0, $signed(a) <= $signed(b)});
      op_lbi:   set_write(r, i.i2.rs, s8);
      op_slbi:  set_write(r, i.i2.rs, (a << 8) | {8'd0, i.i2.imm});
      op_ld:    set_write(r, i.i1.rd, ref_mem[addr[7:0]]);
      op_st: begin
         r.mem_wr   = 1'b1;
         r.mem_addr = addr;
         r.mem_data = ref_regs[i.i1.rd];
         ref_mem[addr[7:0]] = ref_regs[i.i1.rd];
      end
      op_beqz: nxt = (a == 16'd0) ? nxt + s8 : nxt;
      op_bnez: nxt = (a != 16'd0) ? nxt + s8 : nxt;
      op_bltz: nxt = $signed(a) < 0 ? nxt + s8 : nxt;
      op_bgez: nxt = $signed(a) >= 0 ? nxt + s8 : nxt;
      op_j:    nxt = nxt + s11;
      op_jal: begin
         set_write(r, 3'd7, nxt);
         nxt = nxt + s11;
      end
      op_jr:   nxt = a + s8;
      op_jalr: begin
         set_write(r, 3'd7, nxt);
         nxt = a + s8;
      end
      default: begin
         // Unknown opcode stops the core without retiring
         r.valid    = 1'b0;
         ref_halted = 1'b1;
         ref_err    = 1'b1;
      end
   endcase
   if (r.wr_en) begin
      ref_regs[r.wr_reg] = r.wr_data;
   end
   if (!ref_halted) begin
      ref_pc = nxt;
   end
   return r;
endfunction

task automatic fail_run(input string why);
   $display("%s", why);
   $display("SIMULATION FAILED");
   $fatal(1, "stopped at first error");
endtask

task automatic compare_word(input string name, input logic [15:0] got, input logic [15:0] exp);
   if (got !== exp) begin
      fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
   end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
   end
endtask

task automatic compare_retire(input retire_t got, input retire_t exp);
   compare_flag("retire.valid", got.valid, exp.valid);
   if (exp.valid) begin
      compare_word("retire.pc", got.pc, exp.pc);
      compare_flag("retire.wr_en", got.wr_en, exp.wr_en);
      compare_flag("retire.mem_wr", got.mem_wr, exp.mem_wr);
      if (exp.wr_en) begin
         compare_word("retire.wr_reg", 16'(got.wr_reg), 16'(exp.wr_reg));
         compare_word("retire.wr_data", got.wr_data, exp.wr_data);
      end
      if (exp.mem_wr) begin
         compare_word("retire.mem_addr", got.mem_addr, exp.mem_addr);
         compare_word("retire.mem_data", got.mem_data, exp.mem_data);
      end
   end
endtask

`endif

//--- tb/proc_tb.sv
`timescale 1ns/1ps

module proc_tb import isa_pkg::*, core_pkg::*; ();

   localparam int clk_period   = 8;
   localparam int reset_cycles = 10;
   localparam int slack_cycles = 20;

   logic        clk;
   logic        rst;
   logic [15:0] imem_data;
   logic [15:0] imem_addr;
   retire_t     retire;
   logic        halted;
   logic        err;

   logic [15:0] prog [256];
   logic [15:0] image [2][256];
   int          image_len [2];
   logic        checking;
   logic        progs_ready;

   `include "proc_ref.svh"

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   proc proc_i (
      .clk       (clk),
      .rst       (rst),
      .imem_data (imem_data),
      .imem_addr (imem_addr),
      .retire    (retire),
      .halted    (halted),
      .err       (err)
   );

   // Instruction memory answers the fetch address
   always @(posedge clk) begin
      #1 imem_data = prog[imem_addr[7:0]];
   end

   function automatic logic [15:0] enc_r(opcode_t op, logic [2:0] rs, logic [2:0] rt,
                                        logic [2:0] rd, func_t fn);
      return {op, rs, rt, rd, fn};
   endfunction

   function automatic logic [15:0] enc_i1(opcode_t op, logic [2:0] rs, logic [2:0] rd,
                                         logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [15:0] enc_i2(opcode_t op, logic [2:0] rs, logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   task automatic emit(input int run, input logic [15:0] word);
      image[run][image_len[run]] = word;
      image_len[run] = image_len[run] + 1;
   endtask

   task automatic build_images();
      opcode_t     iops [4] = '{op_addi, op_subi, op_xori, op_andni};
      logic [15:0] r;
      logic [2:0]  rs;
      logic [2:0]  rt;
      logic [2:0]  rd;
      logic [1:0]  sel;
      int          base;
      for (int a = 0; a < 256; a++) begin
         // Unused words are HALT tagged with their own address
         image[0][a] = {op_halt, 3'b000, 8'(a)};
         image[1][a] = {op_halt, 3'b000, 8'(a)};
      end
      image_len[0] = 0;
      image_len[1] = 0;
      for (int k = 1; k < 7; k++) begin
         r = rand_bits(16);
         emit(0, enc_i2(op_lbi, 3'(k), r[15:8]));
         emit(0, enc_i2(op_slbi, 3'(k), r[7:0]));
      end
      for (int k = 0; k < 24; k++) begin
         rs  = 3'(rand_bits(3));
         rt  = 3'(rand_bits(3));
         rd  = 3'(rand_bits(3));
         sel = 2'(rand_bits(2));
         case (sel)
            2'd0: emit(0, enc_r(op_alu, rs, rt, rd, 2'(rand_bits(2))));
            2'd1: emit(0, enc_i1(iops[2'(rand_bits(2))], rs, rd, 5'(rand_bits(5))));
            2'd2: begin
               sel = 2'(rand_bits(2));
               // Code 3 gives SLE with equal operands
               if (sel == 2'd3) begin
                  emit(0, enc_r(op_sle, rs, rs, rd, 2'b00));
               end else begin
                  emit(0, enc_r({3'b111, sel}, rs, rt, rd, 2'b00));
               end
            end
            default: emit(0, enc_i2(op_slbi, rs, 8'(rand_bits(8))));
         endcase
      end
      emit(0, enc_i2(op_lbi, 3'd1, 8'd40));
      emit(0, enc_i1(op_st, 3'd1, 3'd5, 5'd3));
      emit(0, enc_i1(op_st, 3'd1, 3'd6, 5'h1e));
      emit(0, enc_i1(op_ld, 3'd1, 3'd2, 5'd3));
      emit(0, enc_i1(op_ld, 3'd1, 3'd3, 5'h1e));
      emit(0, enc_i2(op_lbi, 3'd4, 8'd0));
      emit(0, enc_i2(op_beqz, 3'd4, 8'd1));
      emit(0, enc_i2(op_lbi, 3'd4, 8'h55));
      emit(0, enc_i2(op_bnez, 3'd4, 8'd1));
      emit(0, enc_i2(op_lbi, 3'd4, 8'hfd));
      emit(0, enc_i2(op_bgez, 3'd4, 8'd1));
      emit(0, enc_i2(op_bltz, 3'd4, 8'd1));
      emit(0, enc_i2(op_lbi, 3'd4, 8'h66));
      emit(0, enc_i2(op_bnez, 3'd4, 8'd1));
      emit(0, enc_i2(op_lbi, 3'd4, 8'h11));
      // Opposite outcomes on a positive value
      emit(0, enc_i2(op_lbi, 3'd4, 8'h12));
      emit(0, enc_i2(op_bltz, 3'd4, 8'd1));
      emit(0, enc_i2(op_bgez, 3'd4, 8'd1));
      emit(0, enc_i2(op_lbi, 3'd4, 8'h13));
      emit(0, enc_i2(op_beqz, 3'd4, 8'd1));
      emit(0, {op_nop, 11'd0});
      // Count down loop with a backward branch
      emit(0, enc_i2(op_lbi, 3'd5, 8'd3));
      emit(0, enc_i1(op_addi, 3'd5, 3'd5, 5'h1f));
      emit(0, enc_i2(op_bnez, 3'd5, 8'hfe));
      emit(0, {op_j, 11'd1});
      emit(0, enc_i2(op_lbi, 3'd6, 8'h77));
      emit(0, {op_jal, 11'd1});
      emit(0, enc_i2(op_lbi, 3'd6, 8'h78));
      base = image_len[0];
      emit(0, enc_i2(op_lbi, 3'd2, 8'(base)));
      emit(0, enc_i2(op_jr, 3'd2, 8'd3));
      emit(0, enc_i2(op_lbi, 3'd6, 8'h79));
      emit(0, enc_i2(op_lbi, 3'd3, 8'(base + 7)));
      emit(0, enc_i2(op_jalr, 3'd3, 8'hff));
      emit(0, enc_i2(op_lbi, 3'd6, 8'h7a));
      emit(0, {op_halt, 11'd0});
      emit(1, enc_i2(op_lbi, 3'd1, 8'd5));
      emit(1, enc_i1(op_addi, 3'd1, 3'd2, 5'd3));
      emit(1, {5'b00010, 11'd0});
      emit(1, enc_i1(op_addi, 3'd1, 3'd3, 5'd1));
   endtask

   task automatic load_prog(input int run);
      for (int a = 0; a < 256; a++) begin
         prog[a] = image[run][a];
      end
   endtask

   task automatic do_run(input int run, input logic exp_err);
      @(posedge clk);
      #1;
      rst      = 1'b1;
      checking = 1'b0;
      load_prog(run);
      repeat (reset_cycles) @(posedge clk);
      #1;
      compare_flag("halted", halted, 1'b0);
      compare_flag("err", err, 1'b0);
      compare_flag("retire.valid", retire.valid, 1'b0);
      compare_word("imem_addr", imem_addr, 16'd0);
      reset_ref();
      rst      = 1'b0;
      checking = 1'b1;
      wait (halted === 1'b1);
      // A few stopped cycles to see the PC hold and valid stay low
      repeat (3) @(posedge clk);
      #1;
      compare_flag("err", err, exp_err);
      checking = 1'b0;
   endtask

   always @(posedge clk) begin
      retire_t expected;
      if (checking) begin
         compare_flag("halted", halted, ref_halted);
         compare_flag("err", err, ref_err);
         compare_word("imem_addr", imem_addr, ref_pc);
         if (ref_halted) begin
            compare_flag("retire.valid", retire.valid, 1'b0);
         end else begin
            expected = ref_step(prog[ref_pc[7:0]]);
            compare_retire(retire, expected);
         end
      end
   end

   initial begin
      wait (progs_ready === 1'b1);
      #((image_len[0] + image_len[1] + 2 * slack_cycles) * clk_period);
      fail_run("timeout: the core did not halt within the expected time");
   end

   initial begin
      rst         = 1'b1;
      imem_data   = '0;
      checking    = 1'b0;
      progs_ready = 1'b0;
      lfsr_state  = 32'hcdf5713b;
      build_images();
      load_prog(0);
      progs_ready = 1'b1;
      do_run(0, 1'b0);
      do_run(1, 1'b1);
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

//--- src/proc.sv
`timescale 1ns/1ps

module proc import isa_pkg::*, core_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic [word_w-1:0] imem_data,
   output logic [word_w-1:0] imem_addr,
   output retire_t           retire,
   output logic              halted,
   output logic              err
);

   instr_u            instr;
   ctrl_t             ctrl;
   exec_t             ex;
   logic [word_w-1:0] pc;
   logic [word_w-1:0] pc_inc;
   logic [word_w-1:0] op_a;
   logic [word_w-1:0] op_b;
   logic [word_w-1:0] st_data;
   logic [word_w-1:0] imm_off;
   logic [word_w-1:0] mem_rdata;
   logic [word_w-1:0] wb_data;
   logic              illegal;

   assign instr     = imem_data;
   assign imem_addr = pc;

   // disp11 for J and JAL, imm8 for branches and register jumps
   assign imm_off = (ctrl.jmp && !ctrl.jmp_reg) ?
                    {{(word_w-11){instr.j.disp[10]}}, instr.j.disp} :
                    {{(word_w-8){instr.i2.imm[7]}}, instr.i2.imm};

   fetch fetch_i (
      .clk     (clk),
      .rst     (rst),
      .halt    (ctrl.halt),
      .illegal (illegal),
      .take    (ex.take),
      .target  (ex.target),
      .pc      (pc),
      .pc_inc  (pc_inc),
      .halted  (halted),
      .err     (err)
   );

   decode decode_i (
      .clk     (clk),
      .rst     (rst),
      .instr   (instr),
      .pc_inc  (pc_inc),
      .halted  (halted),
      .wb_data (wb_data),
      .ctrl    (ctrl),
      .op_a    (op_a),
      .op_b    (op_b),
      .st_data (st_data),
      .illegal (illegal)
   );

   execute execute_i (
      .ctrl    (ctrl),
      .op_a    (op_a),
      .op_b    (op_b),
      .pc_inc  (pc_inc),
      .imm_off (imm_off),
      .ex      (ex)
   );

   data_mem data_mem_i (
      .clk   (clk),
      .wr    (ctrl.mem_wr),
      .addr  (ex.alu_out[7:0]),
      .wdata (st_data),
      .rdata (mem_rdata)
   );

   result result_i (
      .ctrl     (ctrl),
      .ex       (ex),
      .mem_data (mem_rdata),
      .pc_inc   (pc_inc),
      .wb_data  (wb_data)
   );

   // One report per executed instruction
   assign retire.valid    = !rst && !halted && !illegal;
   assign retire.pc       = pc;
   assign retire.wr_en    = ctrl.wr_en;
   assign retire.wr_reg   = ctrl.wr_reg;
   assign retire.wr_data  = wb_data;
   assign retire.mem_wr   = ctrl.mem_wr;
   assign retire.mem_addr = ex.alu_out;
   assign retire.mem_data = st_data;

   // Address from execute must be clean for any memory access
   mem_addr_known: assert property (
      @(posedge clk) disable iff (rst)
      (ctrl.mem_rd || ctrl.mem_wr) |-> !$isunknown(ex.alu_out[7:0])
   );

endmodule

//--- src/result.sv
`timescale 1ns/1ps

module result import isa_pkg::*, core_pkg::*; (
   input  ctrl_t             ctrl,
   input  exec_t             ex,
   input  logic [word_w-1:0] mem_data,
   input  logic [word_w-1:0] pc_inc,
   output logic [word_w-1:0] wb_data
);

   always_comb begin
      case (ctrl.wb_sel)
         wb_alu:    wb_data = ex.alu_out;
         wb_mem:    wb_data = mem_data;
         // Link value for JAL and JALR
         wb_pc_inc: wb_data = pc_inc;
         default:   wb_data = {{(word_w-1){1'b0}}, ex.set_flag};
      endcase
   end

endmodule

//--- src/data_mem.sv
`timescale 1ns/1ps

module data_mem (
   input  logic        clk,
   input  logic        wr,
   input  logic [7:0]  addr,
   input  logic [15:0] wdata,
   output logic [15:0] rdata
);

   logic [15:0] mem [256];

   always_ff @(posedge clk) begin
      if (wr) begin
         mem[addr] <= wdata;
      end
   end

   // Read is combinational so LD completes in its own cycle
   assign rdata = mem[addr];

endmodule

//--- src/execute.sv
`timescale 1ns/1ps

module execute import isa_pkg::*, core_pkg::*; (
   input  ctrl_t             ctrl,
   input  logic [word_w-1:0] op_a,
   input  logic [word_w-1:0] op_b,
   input  logic [word_w-1:0] pc_inc,
   input  logic [word_w-1:0] imm_off,
   output exec_t             ex
);

   logic              a_zero;
   logic              cond_ok;
   logic              lt;
   logic              eq;
   logic [word_w-1:0] base;

   always_comb begin
      case (ctrl.alu_op)
         alu_add:      ex.alu_out = op_a + op_b;
         alu_sub_rev:  ex.alu_out = op_b - op_a;
         alu_xor:      ex.alu_out = op_a ^ op_b;
         alu_andn:     ex.alu_out = op_a & ~op_b;
         alu_pass_b:   ex.alu_out = op_b;
         alu_shift_or: ex.alu_out = {op_a[7:0], op_b[7:0]};
         default:      ex.alu_out = op_a + op_b;
      endcase
   end

   // Signed compare of rs against rt for the set group
   assign eq = (op_a == op_b);
   assign lt = ($signed(op_a) < $signed(op_b));

   always_comb begin
      case (ctrl.set_cond)
         set_eq:  ex.set_flag = eq;
         set_lt:  ex.set_flag = lt;
         set_le:  ex.set_flag = lt || eq;
         default: ex.set_flag = 1'b0;
      endcase
   end

   // Branches test rs against zero
   assign a_zero = (op_a == '0);

   always_comb begin
      case (ctrl.br_cond)
         2'b00:   cond_ok = a_zero;
         2'b01:   cond_ok = !a_zero;
         2'b10:   cond_ok = op_a[word_w-1];
         default: cond_ok = !op_a[word_w-1];
      endcase
   end

   assign ex.take = (ctrl.br && cond_ok) || ctrl.jmp;

   // op_a already holds pc+1 for J and JAL
   assign base      = ctrl.br ? pc_inc : op_a;
   assign ex.target = base + imm_off;

endmodule

//--- src/decode.sv
`timescale 1ns/1ps

module decode import isa_pkg::*, core_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  instr_u            instr,
   input  logic [word_w-1:0] pc_inc,
   input  logic              halted,
   input  logic [word_w-1:0] wb_data,
   output ctrl_t             ctrl,
   output logic [word_w-1:0] op_a,
   output logic [word_w-1:0] op_b,
   output logic [word_w-1:0] st_data,
   output logic              illegal
);

   ctrl_t             raw_ctrl;
   logic [word_w-1:0] imm_ext;
   logic [word_w-1:0] q_a;
   logic [word_w-1:0] q_b;
   logic              squash;
   logic              pc_rel;

   // Shared by R-format functions and the immediate ALU group
   function automatic alu_op_t func_to_alu(input func_t f);
      case (f)
         fn_add:  return alu_add;
         fn_sub:  return alu_sub_rev;
         fn_xor:  return alu_xor;
         default: return alu_andn;
      endcase
   endfunction

   always_comb begin
      raw_ctrl = '0;
      imm_ext  = '0;
      illegal  = 1'b0;
      case (instr.r.opcode)
         op_halt: raw_ctrl.halt = 1'b1;
         op_nop: ;
         op_addi, op_subi, op_xori, op_andni: begin
            raw_ctrl.alu_op  = func_to_alu(instr.r.opcode[1:0]);
            raw_ctrl.use_imm = 1'b1;
            raw_ctrl.wr_en   = 1'b1;
            raw_ctrl.wr_reg  = instr.i1.rd;
            imm_ext = {{(word_w-5){instr.i1.imm[4]}}, instr.i1.imm};
         end
         op_st: begin
            raw_ctrl.use_imm = 1'b1;
            raw_ctrl.mem_wr  = 1'b1;
            imm_ext = {{(word_w-5){instr.i1.imm[4]}}, instr.i1.imm};
         end
         op_ld: begin
            raw_ctrl.use_imm = 1'b1;
            raw_ctrl.mem_rd  = 1'b1;
            raw_ctrl.wr_en   = 1'b1;
            raw_ctrl.wr_reg  = instr.i1.rd;
            raw_ctrl.wb_sel  = wb_mem;
            imm_ext = {{(word_w-5){instr.i1.imm[4]}}, instr.i1.imm};
         end
         op_lbi, op_slbi: begin
            // Both write back into rs
            raw_ctrl.use_imm = 1'b1;
            raw_ctrl.wr_en   = 1'b1;
            raw_ctrl.wr_reg  = instr.i2.rs;
            if (instr.r.opcode == op_lbi) begin
               raw_ctrl.alu_op = alu_pass_b;
               imm_ext = {{(word_w-8){instr.i2.imm[7]}}, instr.i2.imm};
            end else begin
               raw_ctrl.alu_op = alu_shift_or;
               imm_ext = {{(word_w-8){1'b0}}, instr.i2.imm};
            end
         end
         op_alu: begin
            raw_ctrl.alu_op = func_to_alu(instr.r.func);
            raw_ctrl.wr_en  = 1'b1;
            raw_ctrl.wr_reg = instr.r.rd;
         end
         op_seq, op_slt, op_sle: begin
            raw_ctrl.wr_en    = 1'b1;
            raw_ctrl.wr_reg   = instr.r.rd;
            raw_ctrl.wb_sel   = wb_set;
            raw_ctrl.set_cond = instr.r.opcode[1:0];
         end
         op_beqz, op_bnez, op_bltz, op_bgez: begin
            raw_ctrl.br      = 1'b1;
            raw_ctrl.br_cond = instr.r.opcode[1:0];
         end
         op_j, op_jr, op_jal, op_jalr: begin
            raw_ctrl.jmp     = 1'b1;
            raw_ctrl.jmp_reg = instr.r.opcode[0];
            // JAL and JALR link into the top register
            if (instr.r.opcode[1]) begin
               raw_ctrl.wr_en  = 1'b1;
               raw_ctrl.wr_reg = 3'(reg_n - 1);
               raw_ctrl.wb_sel = wb_pc_inc;
            end
         end
         default: illegal = 1'b1;
      endcase
   end

   // No state change from a stopped core or a bad opcode
   assign squash = rst || halted || illegal;

   always_comb begin
      ctrl        = raw_ctrl;
      ctrl.wr_en  = raw_ctrl.wr_en && !squash;
      ctrl.mem_wr = raw_ctrl.mem_wr && !squash;
   end

   reg_file reg_file_i (
      .clk     (clk),
      .rst     (rst),
      .rd_a    (instr.r.rs),
      .rd_b    (instr.r.rt),
      .wr_en   (ctrl.wr_en),
      .wr_reg  (ctrl.wr_reg),
      .wr_data (wb_data),
      .q_a     (q_a),
      .q_b     (q_b)
   );

   // J and JAL are relative to the next PC, not to a register
   assign pc_rel  = raw_ctrl.jmp && !raw_ctrl.jmp_reg;
   assign op_a    = pc_rel ? pc_inc : q_a;
   assign op_b    = raw_ctrl.use_imm ? imm_ext : q_b;
   assign st_data = q_b;

   instr_known: assert property (
      @(posedge clk) disable iff (rst)
      !$isunknown(instr)
   );

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file import isa_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic [2:0]        rd_a,
   input  logic [2:0]        rd_b,
   input  logic              wr_en,
   input  logic [2:0]        wr_reg,
   input  logic [word_w-1:0] wr_data,
   output logic [word_w-1:0] q_a,
   output logic [word_w-1:0] q_b
);

   logic [word_w-1:0] regs [reg_n];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < reg_n; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_reg] <= wr_data;
      end
   end

   // Asynchronous reads, old value during a write
   assign q_a = regs[rd_a];
   assign q_b = regs[rd_b];

   wr_reg_known: assert property (
      @(posedge clk) disable iff (rst)
      wr_en |-> !$isunknown(wr_reg)
   );

endmodule

//--- src/fetch.sv
`timescale 1ns/1ps

module fetch import isa_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              halt,
   input  logic              illegal,
   input  logic              take,
   input  logic [word_w-1:0] target,
   output logic [word_w-1:0] pc,
   output logic [word_w-1:0] pc_inc,
   output logic              halted,
   output logic              err
);

   // Word addressed, so the next sequential PC is one up
   assign pc_inc = pc + 1'b1;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc     <= '0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (!halted) begin
         if (illegal) begin
            // Bad opcode stops the core where it is
            halted <= 1'b1;
            err    <= 1'b1;
         end else if (halt) begin
            halted <= 1'b1;
         end else begin
            pc <= take ? target : pc_inc;
         end
      end
   end

   // Once stopped the core must not move on
   pc_hold_when_halted: assert property (
      @(posedge clk) disable iff (rst)
      halted |=> $stable(pc)
   );

endmodule

//--- src/core_pkg.sv
package core_pkg;

   import isa_pkg::*;

   typedef logic [2:0] alu_op_t;

   localparam alu_op_t alu_add      = 3'd0;
   // Second operand minus first
   localparam alu_op_t alu_sub_rev  = 3'd1;
   localparam alu_op_t alu_xor      = 3'd2;
   localparam alu_op_t alu_andn     = 3'd3;
   localparam alu_op_t alu_pass_b   = 3'd4;
   // Low byte of A moved up, byte of B below it
   localparam alu_op_t alu_shift_or = 3'd5;

   typedef logic [1:0] wb_sel_t;

   localparam wb_sel_t wb_alu    = 2'd0;
   localparam wb_sel_t wb_mem    = 2'd1;
   localparam wb_sel_t wb_pc_inc = 2'd2;
   localparam wb_sel_t wb_set    = 2'd3;

   // Same encoding as the low opcode bits of SEQ, SLT, SLE
   localparam logic [1:0] set_eq = 2'd0;
   localparam logic [1:0] set_lt = 2'd1;
   localparam logic [1:0] set_le = 2'd2;

   typedef struct packed {
      alu_op_t    alu_op;
      logic       use_imm;
      logic       wr_en;
      logic [2:0] wr_reg;
      wb_sel_t    wb_sel;
      logic       mem_rd;
      logic       mem_wr;
      logic       br;
      logic [1:0] br_cond;
      logic       jmp;
      logic       jmp_reg;
      logic [1:0] set_cond;
      logic       halt;
   } ctrl_t;

   typedef struct packed {
      logic [word_w-1:0] alu_out;
      logic              set_flag;
      logic              take;
      logic [word_w-1:0] target;
   } exec_t;

   typedef struct packed {
      logic              valid;
      logic [word_w-1:0] pc;
      logic              wr_en;
      logic [2:0]        wr_reg;
      logic [word_w-1:0] wr_data;
      logic              mem_wr;
      logic [word_w-1:0] mem_addr;
      logic [word_w-1:0] mem_data;
   } retire_t;

endpackage

//--- src/isa_pkg.sv
package isa_pkg;

   // Data path and instruction word width
   localparam int word_w = 16;
   localparam int reg_n  = 8;

   typedef logic [4:0] opcode_t;
   typedef logic [1:0] func_t;

   // Control and no-op
   localparam opcode_t op_halt  = 5'b00000;
   localparam opcode_t op_nop   = 5'b00001;

   // Immediate ALU, low two bits follow the R-format function codes
   localparam opcode_t op_addi  = 5'b01000;
   localparam opcode_t op_subi  = 5'b01001;
   localparam opcode_t op_xori  = 5'b01010;
   localparam opcode_t op_andni = 5'b01011;

   // Memory and constant building
   localparam opcode_t op_st    = 5'b10000;
   localparam opcode_t op_ld    = 5'b10001;
   localparam opcode_t op_slbi  = 5'b10010;
   localparam opcode_t op_lbi   = 5'b11000;

   // Register-register ALU and set instructions
   localparam opcode_t op_alu   = 5'b11011;
   localparam opcode_t op_seq   = 5'b11100;
   localparam opcode_t op_slt   = 5'b11101;
   localparam opcode_t op_sle   = 5'b11110;

   // Branches, low two bits select the condition
   localparam opcode_t op_beqz  = 5'b01100;
   localparam opcode_t op_bnez  = 5'b01101;
   localparam opcode_t op_bltz  = 5'b01110;
   localparam opcode_t op_bgez  = 5'b01111;

   // Jumps
   localparam opcode_t op_j     = 5'b00100;
   localparam opcode_t op_jr    = 5'b00101;
   localparam opcode_t op_jal   = 5'b00110;
   localparam opcode_t op_jalr  = 5'b00111;

   localparam func_t fn_add  = 2'b00;
   localparam func_t fn_sub  = 2'b01;
   localparam func_t fn_xor  = 2'b10;
   localparam func_t fn_andn = 2'b11;

   typedef struct packed {
      opcode_t    opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      func_t      func;
   } instr_r_t;

   typedef struct packed {
      opcode_t    opcode;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm;
   } instr_i1_t;

   typedef struct packed {
      opcode_t    opcode;
      logic [2:0] rs;
      logic [7:0] imm;
   } instr_i2_t;

   typedef struct packed {
      opcode_t     opcode;
      logic [10:0] disp;
   } instr_j_t;

   // One fetched word, read through whichever format the opcode implies
   typedef union packed {
      instr_r_t  r;
      instr_i1_t i1;
      instr_i2_t i2;
      instr_j_t  j;
   } instr_u;

endpackage
